// ==== common/csb_macros.svh ====
`ifndef CSB_MACROS_SVH
`define CSB_MACROS_SVH

// Words in one compressed command
`define CSB_CMD_WORDS 6

// Command store, host loaded
`define CSB_STORE_DEPTH 128
`define CSB_STORE_AW ($clog2(`CSB_STORE_DEPTH))  // 7 address bits

// Command FIFO between DMA and controller
`define CSB_FIFO_DEPTH 16
`define CSB_FIFO_AW ($clog2(`CSB_FIFO_DEPTH))    // 4 address bits

// Engine parallelism and address step unit
`define CSB_PARALLEL 16     // Output channels per engine pass
`define CSB_ADDR_SHIFT 4    // Addresses step in units of 16 words

`endif

// ==== common/csb_pkg.sv ====
package csb_pkg;

    // Command stream words
    typedef logic [31:0] cmd_word_t;     // One of the six words of a command

    // Word 0 fields
    typedef logic [2:0]  op_type_t;      // 0 idle, 1..3 conv, 4 max pool, 5 avg pool
    typedef logic [19:0] op_num_t;       // Op number, doubles as the row pitch

    // Addresses
    typedef logic [29:0] dma_addr_t;     // Burst start address seen by the DMA ports
    typedef logic [31:0] mem_addr_t;     // Full address as carried in the command

    // Layer geometry
    typedef logic [15:0] size16_t;       // Channel and surface sizes
    typedef logic [7:0]  side_t;         // Side sizes

    // Fetch bookkeeping
    typedef logic [9:0]  wr_count_t;     // Words ever pushed into the command FIFO
    typedef logic [6:0]  cmd_count_t;    // Commands loaded by the host

    // Controller states
    typedef enum logic [2:0] {
        idle        = 3'd0,  // Waiting for op_en
        cmd_collect = 3'd1,  // Popping the six words of a command
        cmd_issue   = 3'd2,  // Load addresses, raise one engine ready
        wait_op     = 3'd3,  // Counting engine outputs
        finish      = 3'd4   // Raise irq, back to idle
    } csb_state_t;

endpackage

// ==== verilog/cmd_store.sv ====
`include "csb_macros.svh"

module cmd_store import csb_pkg::*; (
    input  logic                     clk,
    input  logic                     i_host_wr_en,   // Host load strobe
    input  logic [`CSB_STORE_AW-1:0] i_host_addr,
    input  cmd_word_t                i_host_data,
    input  logic                     i_rd_en,        // DMA read strobe
    input  logic [`CSB_STORE_AW-1:0] i_rd_addr,
    output cmd_word_t                o_rd_data       // Valid the cycle after i_rd_en
);

    cmd_word_t mem [`CSB_STORE_DEPTH];  // Compressed commands, six words each

    always_ff @(posedge clk) begin
        if (i_host_wr_en)
            mem[i_host_addr] <= i_host_data;
    end

    // Registered read port, output holds until the next read
    always_ff @(posedge clk) begin
        if (i_rd_en)
            o_rd_data <= mem[i_rd_addr];
    end

    // Host loads only while the controller is not fetching
    a_no_load_during_fetch: assert property (
        @(posedge clk) !(i_host_wr_en && i_rd_en)
    ) else $error("cmd_store: host write collides with DMA read");

endmodule

// ==== verilog/cmd_dma_reader.sv ====
`include "csb_macros.svh"

module cmd_dma_reader import csb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_reads_en,     // Fetch window from csb
    input  logic                     i_fifo_full,
    input  cmd_word_t                i_rd_data,      // Store data, one cycle after read
    output logic                     o_rd_en,
    output logic [`CSB_STORE_AW-1:0] o_rd_addr,
    output logic                     o_fifo_wr_en,
    output cmd_word_t                o_fifo_wr_data
);

    logic in_flight;  // One store read whose data has not reached the FIFO yet

    // A full FIFO holds both the pending word and the next read
    // The store output register keeps the pending word meanwhile
    assign o_rd_en        = i_reads_en && !i_fifo_full;
    assign o_fifo_wr_en   = i_reads_en && in_flight && !i_fifo_full;
    assign o_fifo_wr_data = i_rd_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_flight <= 1'b0;
            o_rd_addr <= '0;
        end else begin
            if (o_rd_en)
                in_flight <= 1'b1;       // Replaces a word written this cycle
            else if (o_fifo_wr_en || !i_reads_en)
                in_flight <= 1'b0;       // Drained, or dropped when the window closes

            // Walk the store from word zero for every fetch window
            if (!i_reads_en)
                o_rd_addr <= '0;
            else if (o_rd_en)
                o_rd_addr <= o_rd_addr + 1'b1;
        end
    end

endmodule

// ==== verilog/cmd_fifo.sv ====
`include "csb_macros.svh"

module cmd_fifo import csb_pkg::*; #(
    parameter int FIFO_AW = `CSB_FIFO_AW     // Depth is 2**FIFO_AW
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_wr_en,
    input  cmd_word_t i_wr_data,
    input  logic      i_rd_en,       // Pops o_head at the clock edge
    output cmd_word_t o_head,        // First word falls through
    output logic      o_empty,
    output logic      o_full,
    output wr_count_t o_wr_count     // All words pushed so far, this cycle included
);

    localparam int DEPTH = 1 << FIFO_AW;

    cmd_word_t        mem [DEPTH];
    logic [FIFO_AW:0] wr_ptr, rd_ptr;  // Extra MSB tells full from empty
    wr_count_t        wr_total;        // Registered cumulative count

    assign o_head     = mem[rd_ptr[FIFO_AW-1:0]];
    assign o_empty    = (wr_ptr == rd_ptr);
    assign o_full     = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                        (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign o_wr_count = wr_total + wr_count_t'(i_wr_en);  // Counts a push in its own cycle

    always_ff @(posedge clk) begin
        if (i_wr_en)
            mem[wr_ptr[FIFO_AW-1:0]] <= i_wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            wr_total <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr   <= wr_ptr + 1'b1;
                wr_total <= o_wr_count;    // Never wraps back on reads
            end
            if (i_rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(i_wr_en && o_full))
        else $error("cmd_fifo: write while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(i_rd_en && o_empty))
        else $error("cmd_fifo: read while empty");

endmodule

// ==== csb/csb.sv ====
`include "csb_macros.svh"

module csb import csb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_op_en,             // One-cycle start pulse
    input  cmd_count_t i_cmd_size,          // Commands loaded by the host
    input  cmd_word_t  i_cmd,               // FIFO head
    input  logic       i_cmd_fifo_empty,
    input  wr_count_t  i_cmd_fifo_wr_count,
    input  logic       i_conv_valid,        // One pulse per output position
    input  logic       i_maxpool_valid,
    input  logic       i_avepool_valid,
    output logic       o_cmd_fifo_rd_en,
    output logic       o_dma_p1_reads_en,   // Keeps the DMA copying commands
    output logic       o_conv_ready,
    output logic       o_maxpool_ready,
    output logic       o_avepool_ready,
    output op_type_t   o_op_type,
    output logic       o_padding,
    output logic [3:0] o_stride,
    output op_num_t    o_op_num,
    output dma_addr_t  o_p2_start_addr,     // Data read address, stepped per output
    output dma_addr_t  o_p3_start_addr,     // Weight read address
    output mem_addr_t  o_result_addr,
    output logic       o_engine_reset,
    output logic       o_irq
);

    csb_state_t state;
    logic [2:0] word_idx;     // Word of the current command expected next
    logic       op_done;      // Command over, choose between collect and finish
    logic       last_word;
    logic       hit;          // Counted engine output
    logic       row_end, surf_end, layer_end;
    size16_t    out_chan, out_surf;  // Geometry of the current layer
    side_t      out_side;
    side_t      side_cnt;     // Outputs done in the current row
    size16_t    surf_cnt;     // Outputs done in the current surface
    size16_t    chan_cnt;     // Output channels finished, steps of 16
    mem_addr_t  weight_addr, data_addr;
    dma_addr_t  row_step, col_step;
    wr_count_t  wr_base;      // FIFO write count when the fetch started
    wr_count_t  fetched, load_words;

    // Pop and capture in the same cycle
    assign o_cmd_fifo_rd_en = (state == cmd_collect) && !i_cmd_fifo_empty;
    assign last_word = o_cmd_fifo_rd_en && (word_idx == 3'(`CSB_CMD_WORDS - 1));

    // Only the engine holding ready is counted
    assign hit = (i_conv_valid && o_conv_ready) ||
                 (i_maxpool_valid && o_maxpool_ready) ||
                 (i_avepool_valid && o_avepool_ready);

    assign row_end   = (side_cnt + 8'd1 == out_side);
    assign surf_end  = (surf_cnt + 16'd1 == out_surf);
    assign layer_end = surf_end && (chan_cnt + size16_t'(`CSB_PARALLEL) >= out_chan);

    assign col_step = dma_addr_t'(o_stride) << `CSB_ADDR_SHIFT;  // Next output in the row
    assign row_step = dma_addr_t'(o_op_num) << `CSB_ADDR_SHIFT;  // Jump to the next row

    assign fetched    = i_cmd_fifo_wr_count - wr_base;
    assign load_words = wr_count_t'(i_cmd_size * `CSB_CMD_WORDS);

    // DMA fetch window, closes once every loaded word reached the FIFO
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_dma_p1_reads_en <= 1'b0;
            wr_base           <= '0;
        end else if (state == idle && i_op_en) begin
            o_dma_p1_reads_en <= 1'b1;
            wr_base           <= i_cmd_fifo_wr_count;
        end else if (o_dma_p1_reads_en && fetched == load_words) begin
            o_dma_p1_reads_en <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= idle;
            word_idx        <= '0;
            op_done         <= 1'b0;
            side_cnt        <= '0;
            surf_cnt        <= '0;
            chan_cnt        <= '0;
            o_conv_ready    <= 1'b0;
            o_maxpool_ready <= 1'b0;
            o_avepool_ready <= 1'b0;
            o_engine_reset  <= 1'b1;   // Engines held until the first issue
            o_irq           <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (i_op_en) begin
                        o_irq    <= 1'b0;      // Interrupt acknowledged by the new start
                        word_idx <= '0;
                        state    <= cmd_collect;
                    end
                end
                cmd_collect: begin
                    o_engine_reset <= 1'b1;
                    if (o_cmd_fifo_rd_en)
                        word_idx <= word_idx + 3'd1;
                    if (last_word) begin
                        word_idx <= '0;
                        state    <= cmd_issue;
                    end
                end
                cmd_issue: begin
                    o_engine_reset <= 1'b0;
                    side_cnt       <= '0;
                    surf_cnt       <= '0;
                    chan_cnt       <= '0;
                    state          <= wait_op;
                    case (o_op_type)
                        3'd1, 3'd2, 3'd3: o_conv_ready <= 1'b1;  // All conv variants
                        3'd4:             o_maxpool_ready <= 1'b1;
                        3'd5:             o_avepool_ready <= 1'b1;
                        default:          op_done <= 1'b1;  // Unknown op, skip it
                    endcase
                end
                wait_op: begin
                    if (op_done) begin
                        op_done <= 1'b0;
                        // More words queued or still being fetched
                        if (!i_cmd_fifo_empty || o_dma_p1_reads_en)
                            state <= cmd_collect;
                        else
                            state <= finish;
                    end else if (hit) begin
                        side_cnt <= row_end ? '0 : side_cnt + 8'd1;  // Wraps per row
                        if (surf_end) begin
                            surf_cnt <= '0;
                            chan_cnt <= chan_cnt + size16_t'(`CSB_PARALLEL);
                        end else begin
                            surf_cnt <= surf_cnt + 16'd1;
                        end
                        if (layer_end) begin
                            o_conv_ready    <= 1'b0;
                            o_maxpool_ready <= 1'b0;
                            o_avepool_ready <= 1'b0;
                            op_done         <= 1'b1;
                        end
                    end
                end
                finish: begin
                    o_irq <= 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // Command fields and addresses
    always_ff @(posedge clk) begin
        if (o_cmd_fifo_rd_en) begin
            case (word_idx)
                3'd0: begin
                    o_op_type <= i_cmd[2:0];
                    o_padding <= i_cmd[4];
                    o_stride  <= i_cmd[11:8];
                    o_op_num  <= i_cmd[31:12];
                end
                3'd1: out_chan <= i_cmd[31:16];   // Input channels not needed here
                3'd2: begin
                    out_side <= i_cmd[15:8];
                    out_surf <= i_cmd[31:16];
                end
                3'd3: weight_addr   <= i_cmd;
                3'd4: data_addr     <= i_cmd;
                3'd5: o_result_addr <= i_cmd;
                default: ;
            endcase
        end
        if (state == cmd_issue) begin
            o_p2_start_addr <= dma_addr_t'(data_addr);    // Low 30 bits
            o_p3_start_addr <= dma_addr_t'(weight_addr);
        end else if (hit) begin
            o_p2_start_addr <= o_p2_start_addr + (row_end ? row_step : col_step);
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0({o_conv_ready, o_maxpool_ready, o_avepool_ready}))
        else $error("csb: more than one engine ready");

    // Engine protocol, outputs only while granted
    a_valid_needs_ready: assert property (@(posedge clk) disable iff (rst)
        !(i_conv_valid && !o_conv_ready) && !(i_maxpool_valid && !o_maxpool_ready) &&
        !(i_avepool_valid && !o_avepool_ready))
        else $error("csb: engine valid without its ready");

endmodule

// ==== verilog/csb_top.sv ====
`include "csb_macros.svh"

module csb_top import csb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    // Host load port
    input  logic                     i_host_wr_en,
    input  logic [`CSB_STORE_AW-1:0] i_host_addr,
    input  cmd_word_t                i_host_data,
    input  logic                     i_op_en,
    input  cmd_count_t               i_cmd_size,
    // Engine handshakes
    input  logic                     i_conv_valid,
    input  logic                     i_maxpool_valid,
    input  logic                     i_avepool_valid,
    output logic                     o_conv_ready,
    output logic                     o_maxpool_ready,
    output logic                     o_avepool_ready,
    // Decoded command
    output op_type_t                 o_op_type,
    output logic                     o_padding,
    output logic [3:0]               o_stride,
    output op_num_t                  o_op_num,
    output dma_addr_t                o_p2_start_addr,
    output dma_addr_t                o_p3_start_addr,
    output mem_addr_t                o_result_addr,
    output logic                     o_engine_reset,
    output logic                     o_irq
);

    logic                     store_rd_en;
    logic [`CSB_STORE_AW-1:0] store_rd_addr;
    cmd_word_t                store_rd_data;
    logic                     fifo_wr_en, fifo_rd_en, fifo_empty, fifo_full;
    cmd_word_t                fifo_wr_data, fifo_head;
    wr_count_t                fifo_wr_count;
    logic                     reads_en;      // Fetch window from csb to the reader

    cmd_store store_i (
        .clk(clk), .i_host_wr_en(i_host_wr_en), .i_host_addr(i_host_addr),
        .i_host_data(i_host_data), .i_rd_en(store_rd_en), .i_rd_addr(store_rd_addr),
        .o_rd_data(store_rd_data)
    );

    cmd_dma_reader reader_i (
        .clk(clk), .rst(rst), .i_reads_en(reads_en), .i_fifo_full(fifo_full),
        .i_rd_data(store_rd_data), .o_rd_en(store_rd_en), .o_rd_addr(store_rd_addr),
        .o_fifo_wr_en(fifo_wr_en), .o_fifo_wr_data(fifo_wr_data)
    );

    cmd_fifo #(.FIFO_AW(`CSB_FIFO_AW)) fifo_i (
        .clk(clk), .rst(rst), .i_wr_en(fifo_wr_en), .i_wr_data(fifo_wr_data),
        .i_rd_en(fifo_rd_en), .o_head(fifo_head), .o_empty(fifo_empty),
        .o_full(fifo_full), .o_wr_count(fifo_wr_count)
    );

    csb csb_i (
        .clk(clk), .rst(rst), .i_op_en(i_op_en), .i_cmd_size(i_cmd_size),
        .i_cmd(fifo_head), .i_cmd_fifo_empty(fifo_empty),
        .i_cmd_fifo_wr_count(fifo_wr_count), .i_conv_valid(i_conv_valid),
        .i_maxpool_valid(i_maxpool_valid), .i_avepool_valid(i_avepool_valid),
        .o_cmd_fifo_rd_en(fifo_rd_en), .o_dma_p1_reads_en(reads_en),
        .o_conv_ready(o_conv_ready), .o_maxpool_ready(o_maxpool_ready),
        .o_avepool_ready(o_avepool_ready), .o_op_type(o_op_type), .o_padding(o_padding),
        .o_stride(o_stride), .o_op_num(o_op_num), .o_p2_start_addr(o_p2_start_addr),
        .o_p3_start_addr(o_p3_start_addr), .o_result_addr(o_result_addr),
        .o_engine_reset(o_engine_reset), .o_irq(o_irq)
    );

endmodule

// ==== sim/tb_csb_top.sv ====
`include "csb_macros.svh"

module tb_csb_top import csb_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int MAX_CMDS   = `CSB_STORE_DEPTH / `CSB_CMD_WORDS;  // Commands that fit the store

    logic                     clk;
    logic                     rst;
    logic                     host_wr_en;
    logic [`CSB_STORE_AW-1:0] host_addr;
    cmd_word_t                host_data;
    logic                     op_en;
    cmd_count_t               cmd_size;
    logic                     conv_valid, maxpool_valid, avepool_valid;
    logic                     conv_ready, maxpool_ready, avepool_ready;
    op_type_t                 op_type;
    logic                     padding;
    logic [3:0]               stride;
    op_num_t                  op_num;
    dma_addr_t                p2_addr, p3_addr;
    mem_addr_t                result_addr;
    logic                     engine_reset;
    logic                     irq;

    cmd_word_t trace [0:255];   // Count, six words per command, then one max gap per command
    int        n_cmds;
    int        limit_cycles;    // Watchdog budget, zero until the trace is read
    integer    seed;

    csb_top dut_i (
        .clk(clk), .rst(rst), .i_host_wr_en(host_wr_en), .i_host_addr(host_addr),
        .i_host_data(host_data), .i_op_en(op_en), .i_cmd_size(cmd_size),
        .i_conv_valid(conv_valid), .i_maxpool_valid(maxpool_valid),
        .i_avepool_valid(avepool_valid), .o_conv_ready(conv_ready),
        .o_maxpool_ready(maxpool_ready), .o_avepool_ready(avepool_ready),
        .o_op_type(op_type), .o_padding(padding), .o_stride(stride), .o_op_num(op_num),
        .o_p2_start_addr(p2_addr), .o_p3_start_addr(p3_addr), .o_result_addr(result_addr),
        .o_engine_reset(engine_reset), .o_irq(irq)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic cmd_word_t cmd_word(int c, int w);
        return trace[1 + c * `CSB_CMD_WORDS + w];
    endfunction

    function automatic int max_gap(int c);
        return int'(trace[1 + n_cmds * `CSB_CMD_WORDS + c]);  // Gaps follow the last command
    endfunction

    // Outputs per layer, surface times output channels over 16
    function automatic int valid_count(int c);
        cmd_word_t w1, w2;
        w1 = cmd_word(c, 1);
        w2 = cmd_word(c, 2);
        return int'(w2[31:16]) * int'(w1[31:16]) / 16;
    endfunction

    // Ready pattern {conv, maxpool, avepool} an op type should raise
    function automatic logic [2:0] ready_for(op_type_t t);
        if (t >= 3'd1 && t <= 3'd3)
            return 3'b100;
        else if (t == 3'd4)
            return 3'b010;
        else if (t == 3'd5)
            return 3'b001;
        return 3'b000;         // Unknown op, skipped
    endfunction

    function automatic logic [2:0] readies();
        return {conv_ready, maxpool_ready, avepool_ready};
    endfunction

    function automatic int watchdog_cycles();
        int c;
        int total;
        total = 0;
        for (c = 0; c < n_cmds; c++)
            total += valid_count(c) * (max_gap(c) + 2) + 200;
        return total;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERROR @ %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Host port, one word per cycle from address zero
    task automatic load_store();
        int i;
        for (i = 0; i < n_cmds * `CSB_CMD_WORDS; i++) begin
            @(posedge clk);
            #1;
            host_wr_en = 1'b1;
            host_addr  = i[`CSB_STORE_AW-1:0];
            host_data  = trace[1 + i];
        end
        @(posedge clk);
        #1;
        host_wr_en = 1'b0;
    endtask

    task automatic drive_valid(input logic [2:0] sel, input logic v);
        {conv_valid, maxpool_valid, avepool_valid} = v ? sel : 3'b000;
    endtask

    // Poll once per cycle until some engine gets ready
    task automatic wait_for_ready();
        while (readies() == 3'b000) begin
            @(posedge clk);
            #1;
            check(irq, 1'b0, "irq raised before the last command finished");
        end
    endtask

    task automatic check_issue(input int c);
        cmd_word_t w0;
        w0 = cmd_word(c, 0);
        check(readies(), ready_for(w0[2:0]), "engine ready does not match op type");
        check(op_type, w0[2:0], "op type");
        check(padding, w0[4], "padding");
        check(stride, w0[11:8], "stride");
        check(op_num, w0[31:12], "op number");
        check(p3_addr, dma_addr_t'(cmd_word(c, 3)), "weight address on p3");
        check(p2_addr, dma_addr_t'(cmd_word(c, 4)), "data address on p2");
        check(result_addr, cmd_word(c, 5), "result address");
        check(engine_reset, 1'b0, "engine reset high during wait_op");
    endtask

    // Engine model, one valid per output with random idle gaps
    task automatic run_engine(input int c);
        logic [2:0] sel;
        cmd_word_t  w0, w2;
        dma_addr_t  exp_p2, col_step, row_step;
        int         side, side_pos, n, k, gap;
        w0       = cmd_word(c, 0);
        w2       = cmd_word(c, 2);
        sel      = ready_for(w0[2:0]);
        exp_p2   = dma_addr_t'(cmd_word(c, 4));
        col_step = dma_addr_t'(w0[11:8]) * 16;    // Stride in 16-word units
        row_step = dma_addr_t'(w0[31:12]) * 16;   // Op number is the row pitch
        side     = int'(w2[15:8]);
        side_pos = 0;
        n        = valid_count(c);
        for (k = 0; k < n; k++) begin
            check(readies(), sel, "engine ready dropped before the layer end");
            check(engine_reset, 1'b0, "engine reset high during wait_op");
            drive_valid(sel, 1'b1);
            @(posedge clk);
            #1;
            drive_valid(sel, 1'b0);
            if (side_pos + 1 == side) begin   // Row end jumps by the row pitch
                exp_p2   = exp_p2 + row_step;
                side_pos = 0;
            end else begin
                exp_p2   = exp_p2 + col_step;
                side_pos = side_pos + 1;
            end
            @(posedge clk);
            #1;
            check(p2_addr, exp_p2, "p2 address after valid");
            check(irq, 1'b0, "irq raised during a layer");
            if (k == n - 1)
                check(readies(), 3'b000, "ready still high after the last valid");
            else
                check(readies(), sel, "ready fell before all valids");
            gap = $unsigned($random(seed)) % (max_gap(c) + 1);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_for_irq();
        while (irq !== 1'b1) begin
            @(posedge clk);
            #1;
            check(readies(), 3'b000, "engine ready raised after the last command");
        end
        check(dut_i.reads_en, 1'b0, "reads_en still high at irq");
    endtask

    initial begin
        int c;
        cmd_word_t w0;
        rst           = 1'b1;
        host_wr_en    = 1'b0;
        host_addr     = '0;
        host_data     = '0;
        op_en         = 1'b0;
        cmd_size      = '0;
        conv_valid    = 1'b0;
        maxpool_valid = 1'b0;
        avepool_valid = 1'b0;
        seed          = 32'hdf739d3a;

        $readmemh("sim/csb_trace.txt", trace);
        n_cmds = int'(trace[0]);
        check(n_cmds > 0 && n_cmds <= MAX_CMDS, 1'b1, "trace command count out of range");
        limit_cycles = watchdog_cycles();

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check(engine_reset, 1'b1, "engine reset low after reset");
        check(irq, 1'b0, "irq high after reset");
        check(readies(), 3'b000, "engine ready high after reset");
        check(dut_i.reads_en, 1'b0, "reads_en high after reset");

        load_store();
        cmd_size = cmd_count_t'(n_cmds);
        @(posedge clk);
        #1;
        op_en = 1'b1;          // Single-cycle start
        @(posedge clk);
        #1;
        op_en = 1'b0;

        for (c = 0; c < n_cmds; c++) begin
            w0 = cmd_word(c, 0);
            if (ready_for(w0[2:0]) != 3'b000) begin  // Unknown ops raise nothing
                wait_for_ready();
                check_issue(c);
                run_engine(c);
            end
        end

        wait_for_irq();
        repeat (5) begin
            @(posedge clk);
            #1;
            check(irq, 1'b1, "irq did not stay high");
        end
        $display("** PASS **");
        $finish;
    end

    // Budget from the trace lengths
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * CLK_PERIOD);
        $display("Run timed out after %0d cycles before the trace completed", limit_cycles);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== sim/csb_trace.txt ====
// Line 1 is the command count, then one command per line as six hex words
// word0 word1 word2 weight data result, then one max gap per command
6
// conv op 1, pad 1, stride 1, pitch 5, 32 ch, side 3, surface 9
00005111 00200003 00090305 00001000 40002000 80003000
// max pool op 4, stride 2, pitch 8, 16 ch, side 2, surface 4
00008204 00100010 00040204 00004000 00005000 00006000
// op 0, no engine
00000000 00100010 00040204 11111111 22222222 33333333
// avg pool op 5, stride 1, pitch 4, 48 ch, side 2, surface 4
00004105 00300030 00040204 00007000 C0008000 00009000
// op 6, unknown type
00003216 00100010 00010101 AAAA0000 BBBB0000 CCCC0000
// conv op 3, pad 1, stride 2, pitch 12, 16 ch, data near the 30-bit top
0000C213 00100008 00040206 0000A000 3FFFFFF0 0000B000
// Max gap between valids, one per command
3
2
0
1
0
4

// ==== csb_subsys.f ====
+incdir+common
common/csb_pkg.sv
verilog/cmd_store.sv
verilog/cmd_dma_reader.sv
verilog/cmd_fifo.sv
csb/csb.sv
verilog/csb_top.sv
sim/tb_csb_top.sv
